/* rtl/periph_map_pkg.sv */
package periph_map_pkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------
    // byte address of the register bus
    localparam int AddrWidth = 16;
    localparam int DataWidth = 32;
    // region field starts here, bits below are the in-unit offset
    localparam int RegionLsb = 8;

    // ----------------------------------------
    // region numbers
    // ----------------------------------------
    localparam int RegionGpio      = 0;
    localparam int RegionIrq       = 1;
    // timer i lives at RegionTimerBase + i
    localparam int RegionTimerBase = 2;

    // timer count bounds
    localparam int MaxTimers        = 8;
    localparam int DefaultNumTimers = 4;

    // ----------------------------------------
    // register offsets
    // ----------------------------------------
    // gpio
    localparam logic [RegionLsb-1:0] OffsLeds     = 8'h00;
    localparam logic [RegionLsb-1:0] OffsSwitches = 8'h04;
    // interrupt controller
    localparam logic [RegionLsb-1:0] OffsPending  = 8'h00;
    localparam logic [RegionLsb-1:0] OffsEnable   = 8'h04;
    localparam logic [RegionLsb-1:0] OffsClaim    = 8'h08;
    // timer
    localparam logic [RegionLsb-1:0] OffsCtrl     = 8'h00;
    localparam logic [RegionLsb-1:0] OffsCompare  = 8'h04;
    localparam logic [RegionLsb-1:0] OffsCount    = 8'h08;

    // timer ctrl fields: enable in bit 0, prescale in bits 3:1
    localparam int CtrlEnableBit      = 0;
    localparam int CtrlPrescaleLsb    = 1;
    localparam int CtrlPrescaleWidth  = 3;

    // board io widths
    localparam int LedWidth    = 8;
    localparam int SwitchWidth = 8;

endpackage

/* rtl/periph_bus_pkg.sv */
package periph_bus_pkg;

    // ----------------------------------------
    // master side of the register bus
    // ----------------------------------------
    // single-cycle request strobe, no back-pressure
    typedef struct packed {
        logic                                valid;
        logic                                write;
        logic [periph_map_pkg::AddrWidth-1:0] addr;
        logic [periph_map_pkg::DataWidth-1:0] wdata;
    } reg_req_t;

    // response comes exactly one cycle after the request
    typedef struct packed {
        logic                                valid;
        logic [periph_map_pkg::DataWidth-1:0] rdata;
        logic                                error;
    } reg_resp_t;

    // ----------------------------------------
    // unit side, after region decode
    // ----------------------------------------
    // only the in-region offset is kept
    typedef struct packed {
        logic                                valid;
        logic                                write;
        logic [periph_map_pkg::RegionLsb-1:0] offset;
        logic [periph_map_pkg::DataWidth-1:0] wdata;
    } unit_req_t;

    // registered read data of one unit
    typedef logic [periph_map_pkg::DataWidth-1:0] unit_rdata_t;

endpackage

/* rtl/region_decoder.sv */
`timescale 1ns/1ns

module region_decoder #(
    parameter int NumTimers = periph_map_pkg::DefaultNumTimers
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  periph_bus_pkg::reg_req_t    req_i,
    output periph_bus_pkg::unit_req_t   gpio_req_o,
    output periph_bus_pkg::unit_req_t   irq_req_o,
    output periph_bus_pkg::unit_req_t   timer_req_o [NumTimers],
    input  periph_bus_pkg::unit_rdata_t gpio_rdata_i,
    input  periph_bus_pkg::unit_rdata_t irq_rdata_i,
    input  periph_bus_pkg::unit_rdata_t timer_rdata_i [NumTimers],
    output periph_bus_pkg::reg_resp_t   resp_o
);
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    localparam int NumRegions = RegionTimerBase + NumTimers;
    // sized for the largest build so the select never truncates
    localparam int SelWidth   = $clog2(RegionTimerBase + MaxTimers);

    logic [AddrWidth-RegionLsb-1:0] region;
    logic                           mapped;
    unit_req_t                      unit_req;
    logic                           resp_valid_q;
    logic                           resp_error_q;
    logic [SelWidth-1:0]            sel_q;
    unit_rdata_t                    rdata_mux;

    // ----------------------------------------
    // request side
    // ----------------------------------------
    assign region = req_i.addr[AddrWidth-1:RegionLsb];
    assign mapped = (region < NumRegions);

    // common fields, valid filled in per unit
    assign unit_req = '{
        valid:  1'b0,
        write:  req_i.write,
        offset: req_i.addr[RegionLsb-1:0],
        wdata:  req_i.wdata
    };

    always_comb begin
        gpio_req_o       = unit_req;
        gpio_req_o.valid = req_i.valid && (region == RegionGpio);
        irq_req_o        = unit_req;
        irq_req_o.valid  = req_i.valid && (region == RegionIrq);
    end

    // one strobe per timer region
    for (genvar i = 0; i < NumTimers; i++) begin : gen_timer_req
        always_comb begin
            timer_req_o[i]       = unit_req;
            timer_req_o[i].valid = req_i.valid && (region == RegionTimerBase + i);
        end
    end

    // remember who answers next cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            resp_valid_q <= 1'b0;
            resp_error_q <= 1'b0;
            sel_q        <= '0;
        end else begin
            resp_valid_q <= req_i.valid;
            if (req_i.valid) begin
                resp_error_q <= !mapped;
                sel_q        <= mapped ? region[SelWidth-1:0] : '0;
            end
        end
    end

    // ----------------------------------------
    // response side
    // ----------------------------------------
    always_comb begin
        rdata_mux = '0;
        if (sel_q == SelWidth'(RegionGpio)) begin
            rdata_mux = gpio_rdata_i;
        end
        if (sel_q == SelWidth'(RegionIrq)) begin
            rdata_mux = irq_rdata_i;
        end
        for (int i = 0; i < NumTimers; i++) begin
            if (sel_q == SelWidth'(RegionTimerBase + i)) begin
                rdata_mux = timer_rdata_i[i];
            end
        end
    end

    // unmapped regions answer zero data
    assign resp_o.valid = resp_valid_q;
    assign resp_o.rdata = resp_error_q ? '0 : rdata_mux;
    assign resp_o.error = resp_error_q;

endmodule

/* rtl/timer_unit.sv */
`timescale 1ns/1ns

module timer_unit (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  periph_bus_pkg::unit_req_t   unit_req_i,
    output periph_bus_pkg::unit_rdata_t rdata_o,
    output logic                        irq_o
);
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    logic                         wr_en;
    logic                         enable_q;
    logic [CtrlPrescaleWidth-1:0] prescale_q;
    logic [CtrlPrescaleWidth-1:0] presc_cnt_q;
    logic [DataWidth-1:0]         compare_q;
    logic [DataWidth-1:0]         count_q;
    logic                         tick;
    logic                         match;
    unit_rdata_t                  rdata_d;
    unit_rdata_t                  rdata_q;

    assign wr_en = unit_req_i.valid && unit_req_i.write;

    // ----------------------------------------
    // prescaler and counter
    // ----------------------------------------
    // wrap of the prescaler advances the count
    // >= covers a prescale lowered while running
    assign tick  = enable_q && (presc_cnt_q >= prescale_q);
    assign match = tick && (count_q == compare_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            enable_q    <= 1'b0;
            prescale_q  <= '0;
            presc_cnt_q <= '0;
            compare_q   <= '0;
            count_q     <= '0;
        end else begin
            // prescaler parked at zero while disabled
            if (!enable_q || tick) begin
                presc_cnt_q <= '0;
            end else begin
                presc_cnt_q <= presc_cnt_q + 1'b1;
            end
            // back to zero on compare match
            if (match) begin
                count_q <= '0;
            end else if (tick) begin
                count_q <= count_q + 1'b1;
            end
            // bus writes override the advance
            if (wr_en) begin
                case (unit_req_i.offset)
                    OffsCtrl: begin
                        enable_q   <= unit_req_i.wdata[CtrlEnableBit];
                        prescale_q <= unit_req_i.wdata[CtrlPrescaleLsb +: CtrlPrescaleWidth];
                    end
                    OffsCompare: compare_q <= unit_req_i.wdata;
                    OffsCount:   count_q   <= unit_req_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------
    // read path
    // ----------------------------------------
    always_comb begin
        rdata_d = '0;
        case (unit_req_i.offset)
            OffsCtrl: begin
                rdata_d[CtrlEnableBit]                          = enable_q;
                rdata_d[CtrlPrescaleLsb +: CtrlPrescaleWidth]   = prescale_q;
            end
            OffsCompare: rdata_d = compare_q;
            OffsCount:   rdata_d = count_q;
            default:     rdata_d = '0;
        endcase
    end

    // sampled on the strobe, valid next cycle
    always_ff @(posedge clk_i) begin
        if (unit_req_i.valid) begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;
    // one cycle per match, straight from registers
    assign irq_o   = match;

endmodule

/* rtl/irq_controller.sv */
`timescale 1ns/1ns

module irq_controller #(
    parameter int NumTimers = periph_map_pkg::DefaultNumTimers
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  periph_bus_pkg::unit_req_t   unit_req_i,
    output periph_bus_pkg::unit_rdata_t rdata_o,
    input  logic [NumTimers-1:0]        sources_i,
    output logic                        irq_o
);
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    // claim id is index + 1, zero means none
    localparam int IdxWidth = $clog2(NumTimers + 1);

    logic [NumTimers-1:0] pending_q;
    logic [NumTimers-1:0] enable_q;
    logic [NumTimers-1:0] active;
    logic [NumTimers-1:0] claim_clr;
    logic [IdxWidth-1:0]  claim_id;
    logic                 claim_rd;
    logic                 irq_q;
    unit_rdata_t          rdata_d;
    unit_rdata_t          rdata_q;

    assign active   = pending_q & enable_q;
    assign claim_rd = unit_req_i.valid && !unit_req_i.write && (unit_req_i.offset == OffsClaim);

    // ----------------------------------------
    // claim selection
    // ----------------------------------------
    // walk down so the lowest index is kept last
    always_comb begin
        claim_id  = '0;
        claim_clr = '0;
        for (int i = NumTimers - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id     = IdxWidth'(i + 1);
                claim_clr    = '0;
                claim_clr[i] = 1'b1;
            end
        end
        // only a claim read clears anything
        if (!claim_rd) begin
            claim_clr = '0;
        end
    end

    // pending set beats claim clear on the same bit
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
            enable_q  <= '0;
            irq_q     <= 1'b0;
        end else begin
            pending_q <= (pending_q & ~claim_clr) | sources_i;
            irq_q     <= |active;
            if (unit_req_i.valid && unit_req_i.write && unit_req_i.offset == OffsEnable) begin
                enable_q <= unit_req_i.wdata[NumTimers-1:0];
            end
        end
    end

    // ----------------------------------------
    // read path
    // ----------------------------------------
    always_comb begin
        case (unit_req_i.offset)
            OffsPending: rdata_d = DataWidth'(pending_q);
            OffsEnable:  rdata_d = DataWidth'(enable_q);
            OffsClaim:   rdata_d = DataWidth'(claim_id);
            default:     rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (unit_req_i.valid) begin
            rdata_q <= rdata_d;
        end
    end

    assign rdata_o = rdata_q;
    assign irq_o   = irq_q;

endmodule

/* rtl/gpio_port.sv */
`timescale 1ns/1ns

module gpio_port (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  periph_bus_pkg::unit_req_t             unit_req_i,
    output periph_bus_pkg::unit_rdata_t           rdata_o,
    output logic [periph_map_pkg::LedWidth-1:0]    leds_o,
    input  logic [periph_map_pkg::SwitchWidth-1:0] dip_switches_i
);
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    logic [LedWidth-1:0]    leds_q;
    logic [SwitchWidth-1:0] sw_meta_q;
    logic [SwitchWidth-1:0] sw_sync_q;
    unit_rdata_t            rdata_q;

    // led register, cleared on reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            leds_q <= '0;
        end else if (unit_req_i.valid && unit_req_i.write && unit_req_i.offset == OffsLeds) begin
            leds_q <= unit_req_i.wdata[LedWidth-1:0];
        end
    end

    // two-flop synchronizer, switches are asynchronous
    always_ff @(posedge clk_i) begin
        sw_meta_q <= dip_switches_i;
        sw_sync_q <= sw_meta_q;
    end

    // read data, zero-extended
    always_ff @(posedge clk_i) begin
        if (unit_req_i.valid) begin
            case (unit_req_i.offset)
                OffsLeds:     rdata_q <= DataWidth'(leds_q);
                OffsSwitches: rdata_q <= DataWidth'(sw_sync_q);
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign rdata_o = rdata_q;
    assign leds_o  = leds_q;

endmodule

/* rtl/periph_top.sv */
`timescale 1ns/1ns

module periph_top #(
    parameter int NumTimers = periph_map_pkg::DefaultNumTimers
) (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  periph_bus_pkg::reg_req_t              req_i,
    output periph_bus_pkg::reg_resp_t             resp_o,
    output logic                                  irq_o,
    output logic [periph_map_pkg::LedWidth-1:0]    leds_o,
    input  logic [periph_map_pkg::SwitchWidth-1:0] dip_switches_i
);
    import periph_bus_pkg::*;

    // per-unit request and read data
    unit_req_t            gpio_req;
    unit_req_t            irq_req;
    unit_req_t            timer_req [NumTimers];
    unit_rdata_t          gpio_rdata;
    unit_rdata_t          irq_rdata;
    unit_rdata_t          timer_rdata [NumTimers];
    // timer pulses into the interrupt controller
    logic [NumTimers-1:0] timer_irq;

    // ----------------------------------------
    // decode and response
    // ----------------------------------------
    region_decoder #(
        .NumTimers ( NumTimers )
    ) i_region_decoder (
        .clk_i         ( clk_i       ),
        .reset_i       ( reset_i     ),
        .req_i         ( req_i       ),
        .gpio_req_o    ( gpio_req    ),
        .irq_req_o     ( irq_req     ),
        .timer_req_o   ( timer_req   ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .irq_rdata_i   ( irq_rdata   ),
        .timer_rdata_i ( timer_rdata ),
        .resp_o        ( resp_o      )
    );

    // ----------------------------------------
    // units
    // ----------------------------------------
    gpio_port i_gpio_port (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .unit_req_i     ( gpio_req       ),
        .rdata_o        ( gpio_rdata     ),
        .leds_o         ( leds_o         ),
        .dip_switches_i ( dip_switches_i )
    );

    // single external interrupt target
    irq_controller #(
        .NumTimers ( NumTimers )
    ) i_irq_controller (
        .clk_i      ( clk_i     ),
        .reset_i    ( reset_i   ),
        .unit_req_i ( irq_req   ),
        .rdata_o    ( irq_rdata ),
        .sources_i  ( timer_irq ),
        .irq_o      ( irq_o     )
    );

    for (genvar i = 0; i < NumTimers; i++) begin : gen_timer
        timer_unit i_timer_unit (
            .clk_i      ( clk_i          ),
            .reset_i    ( reset_i        ),
            .unit_req_i ( timer_req[i]   ),
            .rdata_o    ( timer_rdata[i] ),
            .irq_o      ( timer_irq[i]   )
        );
    end

endmodule

/* bench/tb_periph_top.sv */
`timescale 1ns/1ns

module tb_periph_top;
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    localparam int          NumTimers     = 4;
    // whole run is a few hundred cycles, limit leaves a wide margin
    localparam int          TimeoutCycles = 4000;
    localparam logic [31:0] Seed          = 32'd89185;

    // fixed register addresses
    localparam logic [15:0] AddrLeds     = 16'h0000;
    localparam logic [15:0] AddrSwitches = 16'h0004;
    localparam logic [15:0] AddrPending  = 16'h0100;
    localparam logic [15:0] AddrEnable   = 16'h0104;
    localparam logic [15:0] AddrClaim    = 16'h0108;

    logic                   clk;
    logic                   reset;
    reg_req_t               req;
    reg_resp_t              resp;
    logic                   irq;
    logic [LedWidth-1:0]    leds;
    logic [SwitchWidth-1:0] dip_switches;

    // expectation driven along with each request
    logic        chk_rdata;
    logic [31:0] exp_rdata;
    logic        exp_error;
    // same, one cycle later to line up with the response
    logic        chk_q;
    logic [31:0] exp_rdata_q;
    logic        exp_error_q;

    // reference model of the readable registers
    logic [7:0]  leds_m;
    logic [7:0]  switches_m;
    logic [3:0]  enable_m;
    logic [31:0] ctrl_m [NumTimers];
    logic [31:0] compare_m [NumTimers];

    logic [31:0] rng_state;
    int          cycle_cnt = 0;

    periph_top #(
        .NumTimers ( NumTimers )
    ) UUT (
        .clk_i          ( clk          ),
        .reset_i        ( reset        ),
        .req_i          ( req          ),
        .resp_o         ( resp         ),
        .irq_o          ( irq          ),
        .leds_o         ( leds         ),
        .dip_switches_i ( dip_switches )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        chk_q       <= req.valid && chk_rdata;
        exp_rdata_q <= exp_rdata;
        exp_error_q <= exp_error;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TimeoutCycles) begin
            fail_run("timeout, the tests did not finish within the cycle limit");
        end
    end

    // ----------------------------------------
    // response checks
    // ----------------------------------------
    // each strobe answered in the next cycle
    assert property (@(posedge clk) disable iff (reset) req.valid |=> resp.valid)
        else fail_run("no response in the cycle after a request");
    // no response without a request
    assert property (@(posedge clk) disable iff (reset) !req.valid |=> !resp.valid)
        else fail_run("response valid without a request in the cycle before");
    assert property (@(posedge clk) disable iff (reset) chk_q |-> resp.rdata == exp_rdata_q)
        else fail_run($sformatf("Mismatch at %0t: read data %h, expected %h",
            $time, $sampled(resp.rdata), $sampled(exp_rdata_q)));
    assert property (@(posedge clk) disable iff (reset) resp.valid |-> resp.error == exp_error_q)
        else fail_run($sformatf("Mismatch at %0t: error flag %b, expected %b",
            $time, $sampled(resp.error), $sampled(exp_error_q)));

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // 32-bit xorshift
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] timer_addr(input int idx, input logic [7:0] offs);
        return {8'(RegionTimerBase + idx), offs};
    endfunction

    // predicted read data, pending and claim excluded
    function automatic logic [31:0] model_value(input logic [15:0] addr);
        int         region;
        logic [7:0] offs;
        region = int'(addr[15:8]);
        offs   = addr[7:0];
        model_value = '0;
        if (region == RegionGpio && offs == OffsLeds) begin
            model_value = 32'(leds_m);
        end else if (region == RegionGpio && offs == OffsSwitches) begin
            model_value = 32'(switches_m);
        end else if (region == RegionIrq && offs == OffsEnable) begin
            model_value = 32'(enable_m);
        end else if (region >= RegionTimerBase && region < RegionTimerBase + NumTimers) begin
            // ctrl reads back enable and prescale only
            if (offs == OffsCtrl) begin
                model_value = 32'(ctrl_m[region - RegionTimerBase][3:0]);
            end else if (offs == OffsCompare) begin
                model_value = compare_m[region - RegionTimerBase];
            end
        end
    endfunction

    task automatic note_write(input logic [15:0] addr, input logic [31:0] data);
        int region;
        region = int'(addr[15:8]);
        if (region == RegionGpio && addr[7:0] == OffsLeds) begin
            leds_m = data[7:0];
        end else if (region == RegionIrq && addr[7:0] == OffsEnable) begin
            enable_m = data[3:0];
        end else if (region >= RegionTimerBase && region < RegionTimerBase + NumTimers) begin
            if (addr[7:0] == OffsCtrl) begin
                ctrl_m[region - RegionTimerBase] = data;
            end else if (addr[7:0] == OffsCompare) begin
                compare_m[region - RegionTimerBase] = data;
            end
        end
    endtask

    // ----------------------------------------
    // bus driving
    // ----------------------------------------
    // one strobe, 2 ns after the next edge
    task automatic issue_request(input logic wr, input logic [15:0] addr,
                                 input logic [31:0] data, input logic chk,
                                 input logic [31:0] exp);
        @(posedge clk);
        #2;
        req.valid = 1'b1;
        req.write = wr;
        req.addr  = addr;
        req.wdata = data;
        chk_rdata = chk;
        exp_rdata = exp;
        exp_error = (addr[15:8] >= RegionTimerBase + NumTimers);
        if (wr) begin
            note_write(addr, data);
        end
    endtask

    task automatic bus_idle();
        @(posedge clk);
        #2;
        req.valid = 1'b0;
        chk_rdata = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        issue_request(1'b1, addr, data, 1'b0, '0);
        bus_idle();
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp);
        issue_request(1'b0, addr, '0, 1'b1, exp);
        bus_idle();
    endtask

    task automatic read_model(input logic [15:0] addr);
        read_expect(addr, model_value(addr));
    endtask

    // poll irq_o for a bounded number of cycles
    task automatic wait_irq(input logic level, input int max_cycles, input string msg);
        int n;
        n = 0;
        while (irq !== level && n < max_cycles) begin
            wait_cycles(1);
            n++;
        end
        assert (irq === level) else fail_run(msg);
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        reset        = 1'b1;
        req          = '0;
        dip_switches = '0;
        chk_rdata    = 1'b0;
        exp_rdata    = '0;
        exp_error    = 1'b0;
        leds_m       = '0;
        switches_m   = '0;
        enable_m     = '0;
        for (int t = 0; t < NumTimers; t++) begin
            ctrl_m[t]    = '0;
            compare_m[t] = '0;
        end
        rng_state = Seed;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // reset values
        assert (leds === '0 && irq === 1'b0 && resp.valid === 1'b0)
            else fail_run($sformatf("Mismatch at %0t: leds_o %h irq_o %b valid %b after reset",
                $time, leds, irq, resp.valid));
        read_expect(AddrPending, 32'h0);
        read_model(AddrEnable);

        // gpio leds
        repeat (8) begin
            rng_state = next_random(rng_state);
            write_reg(AddrLeds, rng_state);
            assert (leds === leds_m)
                else fail_run($sformatf("Mismatch at %0t: leds_o %h, expected %h",
                    $time, leds, leds_m));
            read_model(AddrLeds);
        end
        // switches, request sampled on the third edge after the change
        repeat (6) begin
            rng_state    = next_random(rng_state);
            dip_switches = rng_state[SwitchWidth-1:0];
            switches_m   = rng_state[7:0];
            wait_cycles(1);
            read_model(AddrSwitches);
        end

        // back-to-back burst, mapped and unmapped
        rng_state = next_random(rng_state);
        issue_request(1'b1, AddrLeds, rng_state, 1'b0, '0);
        issue_request(1'b0, AddrLeds, '0, 1'b1, model_value(AddrLeds));
        issue_request(1'b1, timer_addr(2, OffsCompare), ~rng_state, 1'b0, '0);
        issue_request(1'b0, timer_addr(2, OffsCompare), '0, 1'b1,
                      model_value(timer_addr(2, OffsCompare)));
        // prescale only, timer stays off
        issue_request(1'b1, timer_addr(2, OffsCtrl), rng_state & 32'he, 1'b0, '0);
        issue_request(1'b0, timer_addr(2, OffsCtrl), '0, 1'b1,
                      model_value(timer_addr(2, OffsCtrl)));
        issue_request(1'b0, 16'h0600, '0, 1'b1, '0);
        issue_request(1'b1, 16'hff04, rng_state, 1'b1, '0);
        issue_request(1'b0, timer_addr(0, 8'h0c), '0, 1'b1, '0);
        issue_request(1'b0, AddrSwitches, '0, 1'b1, model_value(AddrSwitches));
        issue_request(1'b0, 16'h0750, '0, 1'b1, '0);
        bus_idle();

        // timer 1 to claim, period 2 x 6 cycles
        write_reg(timer_addr(1, OffsCompare), 32'd5);
        write_reg(AddrEnable, 32'h2);
        write_reg(timer_addr(1, OffsCtrl), 32'h3);
        wait_irq(1'b1, 15, "irq_o did not rise within 15 cycles of enabling timer 1");
        read_expect(AddrClaim, 32'd2);
        write_reg(timer_addr(1, OffsCtrl), 32'h0);
        read_model(timer_addr(1, OffsCtrl));
        read_expect(AddrClaim, 32'd0);
        wait_irq(1'b0, 3, "irq_o stayed high after timer 1 was claimed and disabled");

        // masked sources, then claim order
        write_reg(AddrEnable, 32'h0);
        write_reg(timer_addr(0, OffsCompare), 32'd2);
        write_reg(timer_addr(3, OffsCompare), 32'd2);
        write_reg(timer_addr(0, OffsCtrl), 32'h1);
        write_reg(timer_addr(3, OffsCtrl), 32'h3);
        // both timers fire at least twice in here
        repeat (16) begin
            assert (irq === 1'b0) else fail_run("irq_o went high while all sources were masked");
            wait_cycles(1);
        end
        write_reg(timer_addr(0, OffsCtrl), 32'h0);
        write_reg(timer_addr(3, OffsCtrl), 32'h0);
        read_expect(AddrPending, 32'h9);
        write_reg(AddrEnable, 32'h9);
        read_model(AddrEnable);
        wait_irq(1'b1, 3, "irq_o did not rise after the pending sources were enabled");
        read_expect(AddrClaim, 32'd1);
        read_expect(AddrClaim, 32'd4);
        read_expect(AddrClaim, 32'd0);
        wait_irq(1'b0, 3, "irq_o stayed high after all sources were claimed");

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* list.f */
rtl/periph_map_pkg.sv
rtl/periph_bus_pkg.sv
rtl/region_decoder.sv
rtl/timer_unit.sv
rtl/irq_controller.sv
rtl/gpio_port.sv
rtl/periph_top.sv
bench/tb_periph_top.sv

/* Bender.yml */
package:
  name: periph_subsystem

sources:
  # packages first, map before bus
  - files:
      - rtl/periph_map_pkg.sv
      - rtl/periph_bus_pkg.sv
      - rtl/region_decoder.sv
      - rtl/timer_unit.sv
      - rtl/irq_controller.sv
      - rtl/gpio_port.sv
      - rtl/periph_top.sv

  - target: simulation
    files:
      - bench/tb_periph_top.sv
